//--- design/cpuPkg.sv
//--------------------------------------------------------------------------
// shared widths, opcode/state/ALU enums and the control and flag structs
// of the 6502-style core
//--------------------------------------------------------------------------
`default_nettype none

package cpuPkg;

  localparam int dataWidth = 8;
  localparam int addrWidth = 16;

  typedef logic [dataWidth-1:0] byte_t;
  typedef logic [addrWidth-1:0] addr_t;

  // first opcode address after reset, no vector fetch
  localparam addr_t resetPc = 16'h0200;

  typedef enum byte_t {
    opLdaImm = 8'hA9,
    opLdxImm = 8'hA2,
    opLdyImm = 8'hA0,
    opAdcImm = 8'h69,
    opAndImm = 8'h29,
    opOraImm = 8'h09,
    opEorImm = 8'h49,
    opTax    = 8'hAA,
    opTay    = 8'hA8,
    opTxa    = 8'h8A,
    opTya    = 8'h98,
    opClc    = 8'h18,
    opSec    = 8'h38,
    opClv    = 8'hB8,
    opNop    = 8'hEA,
    opJmpAbs = 8'h4C
  } opcode_e;

  typedef enum logic [1:0] {
    stFetch,
    stOperand,
    stAddrHigh
  } state_e;

  typedef enum logic [2:0] {
    aluPass,
    aluAdc,
    aluAnd,
    aluOr,
    aluEor
  } aluOp_e;

  // selNone stays at zero so an all-zero control word is quiet
  typedef enum logic [1:0] {
    selNone,
    selA,
    selX,
    selY
  } regSel_e;

  typedef struct packed {
    logic n;
    logic v;
    logic z;
    logic c;
  } flags_t;

  typedef struct packed {
    byte_t  result;
    flags_t flags;
  } aluResult_t;

  typedef struct packed {
    logic    hasOperand;
    logic    isJump;
    aluOp_e  aluOp;
    regSel_e srcReg;
    regSel_e dstReg;
    logic    updNz;
    logic    updCv;
    logic    setC;
    logic    clrC;
    logic    clrV;
  } ctrl_t;

  localparam ctrl_t ctrlQuiet = '0;

endpackage

`default_nettype wire

//--- design/cycleControl.sv
//--------------------------------------------------------------------------
// T-step FSM and instruction register with the per-cycle strobes
//--------------------------------------------------------------------------
`default_nettype none

module cycleControl import cpuPkg::*; (
  input  logic    phi2,
  input  logic    rst,
  input  byte_t   dataIn,
  input  ctrl_t   ctrl,
  output opcode_e ir,
  output logic    sync,
  output logic    pcInc,
  output logic    loadLow,
  output logic    jump,
  output logic    execute
);

  state_e state;
  state_e stateNext;
  logic   running;
  logic   irLoad;

  assign running = ~rst;
  assign irLoad = sync;

  always_comb begin
    stateNext = stFetch;
    case (state)
      stFetch: begin
        stateNext = stOperand;
      end
      stOperand: begin
        // only JMP needs a third cycle for the high address byte
        stateNext = ctrl.isJump ? stAddrHigh : stFetch;
      end
      default: begin
        stateNext = stFetch;
      end
    endcase
  end

  always_ff @(posedge phi2) begin
    if (rst) begin
      state <= stFetch;
    end else begin
      state <= stateNext;
    end
  end

  always_ff @(posedge phi2) begin
    if (rst) begin
      ir <= opNop;
    end else if (irLoad) begin
      ir <= opcode_e'(dataIn);
    end
  end

  always_comb begin
    sync    = 1'b0;
    pcInc   = 1'b0;
    loadLow = 1'b0;
    jump    = 1'b0;
    execute = 1'b0;
    if (running) begin
      case (state)
        stFetch: begin
          sync  = 1'b1;
          pcInc = 1'b1;
        end
        stOperand: begin
          // immediate and JMP consume a byte, implied ops do not
          pcInc   = ctrl.hasOperand;
          loadLow = ctrl.isJump;
          execute = ~ctrl.isJump;
        end
        stAddrHigh: begin
          jump = 1'b1;
        end
        default: begin
          sync = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/programCounter.sv
//--------------------------------------------------------------------------
// 16-bit program counter with increment, JMP low-byte hold and jump load
//--------------------------------------------------------------------------
`default_nettype none

module programCounter import cpuPkg::*; (
  input  logic  phi2,
  input  logic  rst,
  input  logic  pcInc,
  input  logic  loadLow,
  input  logic  jump,
  input  byte_t dataIn,
  output addr_t addr
);

  addr_t pc;
  byte_t lowHold;
  byte_t pcLowNext;
  logic  lowCarry;

  // low byte first, carry ripples into the high byte
  assign {lowCarry, pcLowNext} = {1'b0, pc[7:0]} + 9'd1;

  always_ff @(posedge phi2) begin
    if (rst) begin
      pc <= resetPc;
    end else if (jump) begin
      pc <= {dataIn, lowHold};
    end else if (pcInc) begin
      pc <= {pc[15:8] + {7'd0, lowCarry}, pcLowNext};
    end
  end

  always_ff @(posedge phi2) begin
    if (loadLow) begin
      lowHold <= dataIn;
    end
  end

  assign addr = pc;

endmodule

`default_nettype wire

//--- design/instrDecode.sv
//--------------------------------------------------------------------------
// opcode to control word decode
//--------------------------------------------------------------------------
`default_nettype none

module instrDecode import cpuPkg::*; (
  input  opcode_e ir,
  output ctrl_t   ctrl
);

  always_comb begin
    ctrl = ctrlQuiet;
    case (ir)
      opLdaImm, opLdxImm, opLdyImm: begin
        ctrl.hasOperand = 1'b1;
        ctrl.updNz      = 1'b1;
        ctrl.dstReg     = (ir == opLdaImm) ? selA :
                          (ir == opLdxImm) ? selX : selY;
      end
      opAdcImm: begin
        ctrl.hasOperand = 1'b1;
        ctrl.aluOp      = aluAdc;
        ctrl.dstReg     = selA;
        ctrl.updNz      = 1'b1;
        ctrl.updCv      = 1'b1;
      end
      opAndImm, opOraImm, opEorImm: begin
        ctrl.hasOperand = 1'b1;
        ctrl.dstReg     = selA;
        ctrl.updNz      = 1'b1;
        ctrl.aluOp      = (ir == opAndImm) ? aluAnd :
                          (ir == opOraImm) ? aluOr : aluEor;
      end
      opTax, opTay: begin
        ctrl.srcReg = selA;
        ctrl.dstReg = (ir == opTax) ? selX : selY;
        ctrl.updNz  = 1'b1;
      end
      opTxa, opTya: begin
        ctrl.srcReg = (ir == opTxa) ? selX : selY;
        ctrl.dstReg = selA;
        ctrl.updNz  = 1'b1;
      end
      opClc: begin
        ctrl.clrC = 1'b1;
      end
      opSec: begin
        ctrl.setC = 1'b1;
      end
      opClv: begin
        ctrl.clrV = 1'b1;
      end
      opJmpAbs: begin
        ctrl.hasOperand = 1'b1;
        ctrl.isJump     = 1'b1;
      end
      // NOP and anything unknown keep the quiet word
      default: begin
        ctrl = ctrlQuiet;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/alu.sv
//--------------------------------------------------------------------------
// 8-bit ALU: pass, binary add with carry, AND, OR, EOR and NVZC flags
//--------------------------------------------------------------------------
`default_nettype none

module alu import cpuPkg::*; (
  input  byte_t      a,
  input  byte_t      b,
  input  logic       cin,
  input  aluOp_e     op,
  output aluResult_t result
);

  logic [dataWidth:0] sum;
  byte_t              res;
  logic               overflow;

  always_comb begin
    sum = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, cin};
    // signed overflow: operands agree in sign, sum does not
    overflow = (a[dataWidth-1] == b[dataWidth-1]) &&
               (sum[dataWidth-1] != a[dataWidth-1]);
  end

  always_comb begin
    case (op)
      aluAdc: begin
        res = sum[dataWidth-1:0];
      end
      aluAnd: begin
        res = a & b;
      end
      aluOr: begin
        res = a | b;
      end
      aluEor: begin
        res = a ^ b;
      end
      default: begin
        res = b;
      end
    endcase
  end

  always_comb begin
    result.result  = res;
    result.flags.n = res[dataWidth-1];
    result.flags.z = (res == '0);
    // C and V only mean something for the add
    result.flags.c = (op == aluAdc) ? sum[dataWidth] : 1'b0;
    result.flags.v = (op == aluAdc) ? overflow : 1'b0;
  end

endmodule

`default_nettype wire

//--- design/regFile.sv
//--------------------------------------------------------------------------
// A, X, Y and status registers with ALU source select and write-back
//--------------------------------------------------------------------------
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic       phi2,
  input  logic       rst,
  input  logic       execute,
  input  ctrl_t      ctrl,
  input  byte_t      operand,
  input  aluResult_t aluRes,
  output byte_t      aluA,
  output byte_t      aluB,
  output logic       carry,
  output byte_t      regA,
  output byte_t      regX,
  output byte_t      regY,
  output flags_t     status
);

  always_comb begin
    case (ctrl.srcReg)
      selA:    aluB = regA;
      selX:    aluB = regX;
      selY:    aluB = regY;
      default: aluB = operand;
    endcase
  end

  assign aluA  = regA;
  assign carry = status.c;

  always_ff @(posedge phi2) begin
    if (rst) begin
      regA   <= '0;
      regX   <= '0;
      regY   <= '0;
      status <= '0;
    end else if (execute) begin
      case (ctrl.dstReg)
        selA:    regA <= aluRes.result;
        selX:    regX <= aluRes.result;
        selY:    regY <= aluRes.result;
        default: regA <= regA;
      endcase
      if (ctrl.updNz) begin
        status.n <= aluRes.flags.n;
        status.z <= aluRes.flags.z;
      end
      if (ctrl.updCv) begin
        status.c <= aluRes.flags.c;
        status.v <= aluRes.flags.v;
      end
      // flag instructions never share a word with updCv
      if (ctrl.setC) status.c <= 1'b1;
      if (ctrl.clrC) status.c <= 1'b0;
      if (ctrl.clrV) status.v <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/cpuCore.sv
//--------------------------------------------------------------------------
// core top level: sequencer, PC, decode, ALU and register file
//--------------------------------------------------------------------------
`default_nettype none

module cpuCore import cpuPkg::*; (
  input  logic   phi2,
  input  logic   rst,
  input  byte_t  dataIn,
  output addr_t  addr,
  output logic   sync,
  output byte_t  regA,
  output byte_t  regX,
  output byte_t  regY,
  output flags_t status
);

  opcode_e    ir;
  ctrl_t      ctrl;
  logic       pcInc;
  logic       loadLow;
  logic       jump;
  logic       execute;
  byte_t      aluA;
  byte_t      aluB;
  logic       carry;
  aluResult_t aluRes;

  cycleControl ctl0 (
    .phi2    (phi2),
    .rst     (rst),
    .dataIn  (dataIn),
    .ctrl    (ctrl),
    .ir      (ir),
    .sync    (sync),
    .pcInc   (pcInc),
    .loadLow (loadLow),
    .jump    (jump),
    .execute (execute)
  );

  programCounter pc0 (
    .phi2    (phi2),
    .rst     (rst),
    .pcInc   (pcInc),
    .loadLow (loadLow),
    .jump    (jump),
    .dataIn  (dataIn),
    .addr    (addr)
  );

  instrDecode dec0 (
    .ir   (ir),
    .ctrl (ctrl)
  );

  alu alu0 (
    .a      (aluA),
    .b      (aluB),
    .cin    (carry),
    .op     (ctrl.aluOp),
    .result (aluRes)
  );

  // the immediate operand is the data byte of the operand cycle
  regFile regs0 (
    .phi2    (phi2),
    .rst     (rst),
    .execute (execute),
    .ctrl    (ctrl),
    .operand (dataIn),
    .aluRes  (aluRes),
    .aluA    (aluA),
    .aluB    (aluB),
    .carry   (carry),
    .regA    (regA),
    .regX    (regX),
    .regY    (regY),
    .status  (status)
  );

endmodule

`default_nettype wire

//--- tests/cpuCoreTb.sv
//--------------------------------------------------------------------------
// testbench: clock, memory window, random program, instruction model, checks
//--------------------------------------------------------------------------
`default_nettype none

module cpuCoreTb import cpuPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod = 40;
  localparam int memSize = 4096;
  localparam int tailStart = memSize - 7;
  localparam int instrTotal = 600;
  localparam int cycleLimit = 3 * instrTotal + 50;

  logic   phi2;
  logic   rst;
  byte_t  dataIn;
  addr_t  addr;
  logic   sync;
  byte_t  regA;
  byte_t  regX;
  byte_t  regY;
  flags_t status;

  byte_t       mem [memSize];
  byte_t       opTable [16];
  logic [31:0] seed = 32'ha059df9a;
  int          cycleCount = 0;
  int          lastSync;
  int          instrCount = 0;
  int          expectGap;
  byte_t       mA;
  byte_t       mX;
  byte_t       mY;
  flags_t      mFlags;
  addr_t       mPc;

  cpuCore dut0 (
    .phi2   (phi2),
    .rst    (rst),
    .dataIn (dataIn),
    .addr   (addr),
    .sync   (sync),
    .regA   (regA),
    .regX   (regX),
    .regY   (regY),
    .status (status)
  );

  initial begin
    phi2 = 1'b0;
    forever #(clkPeriod / 2) phi2 = ~phi2;
  end

  // window 0200..11FF, anything outside reads as NOP
  function automatic byte_t memRead(addr_t a);
    addr_t off;
    off = a - resetPc;
    if (a >= resetPc && off < addr_t'(memSize)) return mem[off[11:0]];
    return 8'hEA;
  endfunction

  assign dataIn = memRead(addr);

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // 4C only ever appears as a real JMP opcode
  function automatic byte_t randomByte();
    logic [31:0] r;
    byte_t       v;
    r = nextRand();
    v = r[23:16];
    return (v == 8'h4C) ? 8'h4D : v;
  endfunction

  // never the last three bytes, never a low byte of 4C
  function automatic addr_t randomTarget();
    addr_t t;
    t = resetPc + addr_t'(nextRand() % (memSize - 3));
    if (t[7:0] == 8'h4C) t = t + 16'd1;
    return t;
  endfunction

  function automatic int instrLength(byte_t op);
    case (op)
      opLdaImm, opLdxImm, opLdyImm, opAdcImm, opAndImm, opOraImm, opEorImm: return 2;
      opJmpAbs: return 3;
      default: return 1;
    endcase
  endfunction

  task automatic buildProgram();
    int          pos;
    int          len;
    logic [31:0] r;
    byte_t       op;
    addr_t       target;
    for (int i = 0; i < memSize; i++) begin
      mem[i] = opNop;
    end
    pos = 0;
    while (pos < tailStart) begin
      r = nextRand();
      op = (r[31:28] == 4'h0) ? randomByte() : opTable[r[27:24]];
      len = instrLength(op);
      if (pos + len > tailStart) begin
        pos = tailStart;
      end else begin
        mem[pos] = op;
        target = randomTarget();
        if (len == 2) mem[pos + 1] = randomByte();
        if (len == 3) begin
          mem[pos + 1] = target[7:0];
          mem[pos + 2] = target[15:8];
        end
        pos = pos + len;
      end
    end
    // sequential code leaves the window only through this JMP
    target = randomTarget();
    mem[memSize - 3] = opJmpAbs;
    mem[memSize - 2] = target[7:0];
    mem[memSize - 1] = target[15:8];
  endtask

  task automatic abortRun(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic checkAddr(string name, addr_t exp, addr_t act);
    if (exp !== act) begin
      abortRun($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic checkByte(string name, byte_t exp, byte_t act);
    if (exp !== act) begin
      abortRun($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic checkFlags(string name, flags_t exp, flags_t act);
    if (exp !== act) begin
      abortRun($sformatf("CHECK FAILED %s expected nvzc=%b actual nvzc=%b", name, exp, act));
    end
  endtask

  task automatic checkCount(string name, int exp, int act);
    if (exp != act) begin
      abortRun($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic updateNz(byte_t v);
    mFlags.n = v[7];
    mFlags.z = (v == 8'h00);
  endtask

  // one whole instruction at mPc
  task automatic stepModel();
    byte_t op;
    byte_t opnd;
    int    total;
    int    sTotal;
    op = memRead(mPc);
    opnd = memRead(mPc + 16'd1);
    expectGap = 2;
    mPc = mPc + addr_t'(instrLength(op));
    case (op)
      opLdaImm: mA = opnd;
      opLdxImm: mX = opnd;
      opLdyImm: mY = opnd;
      opAdcImm: begin
        // unsigned total gives the carry, signed total the overflow
        total = int'(mA) + int'(opnd) + int'(mFlags.c);
        sTotal = int'($signed(mA)) + int'($signed(opnd)) + int'(mFlags.c);
        mFlags.v = (sTotal > 127) || (sTotal < -128);
        mFlags.c = (total > 255);
        mA = byte_t'(total);
      end
      opAndImm: mA = mA & opnd;
      opOraImm: mA = mA | opnd;
      opEorImm: mA = mA ^ opnd;
      opTax: mX = mA;
      opTay: mY = mA;
      opTxa: mA = mX;
      opTya: mA = mY;
      opClc: mFlags.c = 1'b0;
      opSec: mFlags.c = 1'b1;
      opClv: mFlags.v = 1'b0;
      opJmpAbs: begin
        mPc = {memRead(mPc - 16'd1), opnd};
        expectGap = 3;
      end
      default: ;
    endcase
    case (op)
      opLdaImm, opAdcImm, opAndImm, opOraImm, opEorImm, opTxa, opTya: updateNz(mA);
      opLdxImm, opTax: updateNz(mX);
      opLdyImm, opTay: updateNz(mY);
      default: ;
    endcase
  endtask

  always @(posedge phi2) begin
    if (!rst) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
        abortRun($sformatf("timeout: only %0d instructions seen in %0d cycles",
                           instrCount, cycleCount));
      end
    end
  end

  initial begin
    rst = 1'b1;
    opTable = '{opLdaImm, opLdxImm, opLdyImm, opAdcImm, opAndImm, opOraImm,
                opEorImm, opTax, opTay, opTxa, opTya, opClc, opSec, opClv,
                opNop, opJmpAbs};
    buildProgram();
    mA = '0;
    mX = '0;
    mY = '0;
    mFlags = '0;
    mPc = resetPc;
    repeat (4) @(posedge phi2);
    @(negedge phi2);
    rst = 1'b0;
    while (instrCount < instrTotal) begin
      // outputs settle well before the rising edge
      #(clkPeriod / 4);
      if (sync) begin
        if (instrCount > 0) begin
          checkCount($sformatf("sync gap before instr %0d", instrCount), expectGap,
                     cycleCount - lastSync);
        end
        checkAddr($sformatf("addr at instr %0d", instrCount), mPc, addr);
        checkByte($sformatf("A at instr %0d", instrCount), mA, regA);
        checkByte($sformatf("X at instr %0d", instrCount), mX, regX);
        checkByte($sformatf("Y at instr %0d", instrCount), mY, regY);
        checkFlags($sformatf("flags at instr %0d", instrCount), mFlags, status);
        stepModel();
        lastSync = cycleCount;
        instrCount++;
      end
      @(negedge phi2);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
design/cpuPkg.sv
design/cycleControl.sv
design/programCounter.sv
design/instrDecode.sv
design/alu.sv
design/regFile.sv
design/cpuCore.sv
tests/cpuCoreTb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - design/cpuPkg.sv
  - design/cycleControl.sv
  - design/programCounter.sv
  - design/instrDecode.sv
  - design/alu.sv
  - design/regFile.sv
  - design/cpuCore.sv
  - target: test
    files:
      - tests/cpuCoreTb.sv
